// ==== common/mem_bus_pkg.sv ====
/* Lines are 16 bytes and move as four 32-bit beats. Source and destination tags
   are one-hot, with bit 0 for the instruction cache, bit 1 for the data cache and bit 2 for DMA */
package mem_bus_pkg;

   // Line geometry
   localparam int beats     = 4;
   localparam int beat_bits = $clog2(beats);
   localparam int line_bits = 32 * beats;
   localparam int row_bytes = 2 * line_bits / 8;

   ////////////////////////////////////////////////////////////
   // Bus side

   // Driven by a requester
   typedef struct packed {
      logic        valid;
      logic        rw;      // 1 = write
      logic [15:0] addr;
      logic [2:0]  src;
      logic [31:0] data;
   } bus_req_t;

   // Driven by the controller while it owns the bus
   typedef struct packed {
      logic        drive;
      logic [2:0]  dest;
      logic [31:0] data;
   } bus_rsp_t;

   ////////////////////////////////////////////////////////////
   // Memory side

   // One request as held in the write latch or the memory stage
   typedef struct packed {
      logic                 rw;
      logic [15:0]          addr;
      logic [2:0]           src;
      logic [line_bits-1:0] line;
   } mem_entry_t;

   // A bank row, read by half and written by byte
   typedef union packed {
      logic [1:0][line_bits-1:0] half;
      logic [row_bytes-1:0][7:0] bytes;
   } mem_row_u;

endpackage

// ==== bus_ctrl/bus_ctrl.sv ====
`timescale 1ns/1ns
/* Write beats must come with valid high. A gap in valid stalls the slave phase.
   A finished read waiting for the bus wins over a new address cycle */
module bus_ctrl import mem_bus_pkg::*;
(
   input  logic                 bus_clk,
   input  logic                 arst_n,
   input  bus_req_t             bus_in,
   input  logic                 bg,
   input  logic                 wr_full,
   input  logic                 stage_read_ready,
   output logic                 ack,
   output logic                 br,
   output logic                 load_wr,
   output logic                 beat_en,
   output logic [beat_bits-1:0] beat_idx,
   output logic                 resp_drive,
   output logic                 resp_done
);

   // One-hot state bits
   localparam int s_idle = 0;
   localparam int s_slv  = 1;
   localparam int s_ack  = 2;
   localparam int s_br   = 3;
   localparam int s_mstr = 4;

   logic [4:0]           state;
   logic [4:0]           next_state;
   logic [beat_bits-1:0] beat_cnt;
   logic                 last_beat;
   logic                 accept;
   logic                 req_is_wr;

   ////////////////////////////////////////////////////////////
   // Decode

   assign last_beat = (beat_cnt == '0);
   assign accept    = state[s_idle] & ~stage_read_ready & bus_in.valid & ~wr_full;
   assign beat_en   = state[s_slv] & bus_in.valid;

   // Header on accept, line on the last write beat
   assign load_wr = accept | (beat_en & last_beat);

   assign ack        = state[s_ack];
   assign br         = state[s_br];
   assign resp_drive = state[s_mstr];
   assign resp_done  = state[s_mstr] & last_beat;

   // Counter runs down while the word index runs up
   assign beat_idx = ~beat_cnt;

   ////////////////////////////////////////////////////////////
   // Next state

   always_comb
   begin
      next_state = '0;
      unique case (1'b1)
         state[s_idle]:
         begin
            if (stage_read_ready)
               next_state[s_br] = 1'b1;
            else if (accept)
               next_state[s_ack] = 1'b1;
            else
               next_state[s_idle] = 1'b1;
         end
         state[s_ack]:
         begin
            if (req_is_wr)
               next_state[s_slv] = 1'b1;
            else
               next_state[s_idle] = 1'b1;
         end
         state[s_slv]:
         begin
            if (beat_en && last_beat)
               next_state[s_idle] = 1'b1;
            else
               next_state[s_slv] = 1'b1;
         end
         state[s_br]:
         begin
            if (bg)
               next_state[s_mstr] = 1'b1;
            else
               next_state[s_br] = 1'b1;
         end
         state[s_mstr]:
         begin
            if (last_beat)
               next_state[s_idle] = 1'b1;
            else
               next_state[s_mstr] = 1'b1;
         end
         default:
            next_state[s_idle] = 1'b1;
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= 5'b00001;
         beat_cnt  <= '1;
         req_is_wr <= 1'b0;
      end
      else
      begin
         state <= next_state;
         // Reload before each burst
         if (state[s_ack] || state[s_br])
            beat_cnt <= beat_bits'(beats - 1);
         else if (beat_en || state[s_mstr])
            beat_cnt <= beat_cnt - 1'b1;
         if (accept)
            req_is_wr <= bus_in.rw;
      end
   end

endmodule

// ==== verilog/req_latches.sv ====
`timescale 1ns/1ns
/* A write holds the latch from its header until its last beat. A read in the
   stage stays there until the bus return ends */
module req_latches import mem_bus_pkg::*;
(
   input  logic                 bus_clk,
   input  logic                 arst_n,
   input  bus_req_t             bus_in,
   input  logic                 load_wr,
   input  logic [line_bits-1:0] line_in,
   input  logic                 mem_done,
   input  logic                 resp_done,
   output logic                 wr_full,
   output mem_entry_t           stage,
   output logic                 stage_valid,
   output logic                 stage_read_ready
);

   mem_entry_t wr_entry;
   logic       wr_valid;
   logic       wr_hdr;      // header taken, beats still coming
   logic       wr_commit;
   logic       stage_clear;
   logic       move;

   assign wr_commit   = stage_valid & stage.rw & mem_done;
   assign stage_clear = wr_commit | resp_done;
   assign move        = wr_valid & (~stage_valid | stage_clear);
   assign wr_full     = wr_valid | wr_hdr;

   ////////////////////////////////////////////////////////////
   // Write latch

   always_ff @(posedge bus_clk)
   begin
      if (load_wr && !wr_hdr)
      begin
         wr_entry.rw   <= bus_in.rw;
         wr_entry.addr <= bus_in.addr;
         wr_entry.src  <= bus_in.src;
      end
      if (load_wr && wr_hdr)
         wr_entry.line <= line_in;
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_hdr   <= 1'b0;
         wr_valid <= 1'b0;
      end
      else
      begin
         if (load_wr)
            wr_hdr <= ~wr_hdr & bus_in.rw;
         // A read is complete at its header
         if (load_wr && (wr_hdr || !bus_in.rw))
            wr_valid <= 1'b1;
         else if (move)
            wr_valid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Memory stage

   always_ff @(posedge bus_clk)
   begin
      if (move)
         stage <= wr_entry;
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         stage_valid      <= 1'b0;
         stage_read_ready <= 1'b0;
      end
      else
      begin
         if (move)
            stage_valid <= 1'b1;
         else if (stage_clear)
            stage_valid <= 1'b0;
         if (stage_clear)
            stage_read_ready <= 1'b0;
         else if (stage_valid && !stage.rw && mem_done)
            stage_read_ready <= 1'b1;
      end
   end

endmodule

// ==== verilog/line_buffer.sv ====
`timescale 1ns/1ns
/* line_out already holds the beat being taken, so the last beat can be latched
   in its own cycle. bus_out is quiet when resp_drive is low */
module line_buffer import mem_bus_pkg::*;
(
   input  logic                 bus_clk,
   input  logic                 arst_n,
   input  bus_req_t             bus_in,
   input  logic                 beat_en,
   input  logic [beat_bits-1:0] beat_idx,
   input  logic                 rd_load,
   input  logic [line_bits-1:0] rd_half,
   input  logic                 resp_drive,
   output logic [line_bits-1:0] line_out,
   output bus_rsp_t             bus_out,
   input  logic [2:0]           dest
);

   logic [beats-1:0][31:0] wr_words;
   logic [beats-1:0][31:0] rd_words;

   // Write side collects beat i into word i
   always_ff @(posedge bus_clk)
   begin
      if (beat_en)
         wr_words[beat_idx] <= bus_in.data;
   end

   always_comb
   begin
      line_out = wr_words;
      if (beat_en)
         line_out[32*beat_idx +: 32] = bus_in.data;
   end

   // Read side holds the half picked by the bank
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_words <= '0;
      else if (rd_load)
         rd_words <= rd_half;
   end

   always_comb
   begin
      bus_out.drive = resp_drive;
      bus_out.dest  = resp_drive ? dest : 3'b000;
      bus_out.data  = resp_drive ? rd_words[beat_idx] : 32'h0;
   end

endmodule

// ==== verilog/mem_timer.sv ====
`timescale 1ns/1ns
/* mem_lat must be at least 1. The count restarts when the stage empties or a
   write commits */
module mem_timer #(parameter int mem_lat = 3)
(
   input  logic bus_clk,
   input  logic arst_n,
   input  logic stage_valid,
   input  logic stage_rw,
   output logic mem_en,
   output logic mem_wr,
   output logic mem_done
);

   // One more bit set each cycle of the access
   logic [mem_lat:0] therm;
   logic             restart;

   assign mem_done = stage_valid & therm[mem_lat-1] & ~therm[mem_lat];
   assign mem_en   = stage_valid & ~therm[mem_lat];
   assign mem_wr   = mem_done & stage_rw;
   assign restart  = ~stage_valid | mem_wr;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         therm <= '0;
      else if (restart)
         therm <= '0;
      else
         therm <= {therm[mem_lat-1:0], 1'b1};
   end

endmodule

// ==== verilog/byte_shifter.sv ====
`timescale 1ns/1ns
/* Bytes below the offset are zero filled and left disabled */
module byte_shifter import mem_bus_pkg::*;
(
   input  logic [line_bits-1:0]   line_in,
   input  logic [3:0]             offset,
   output logic [line_bits-1:0]   line_out,
   output logic [line_bits/8-1:0] byte_en
);

   logic [line_bits-1:0] fine_shift;

   // Bytes within a word first, then whole words
   always_comb
   begin
      fine_shift = line_in << {offset[1:0], 3'b000};
      line_out   = fine_shift << {offset[3:2], 5'b00000};
   end

   always_comb
   begin
      for (int b = 0; b < line_bits/8; b++)
         byte_en[b] = (b >= int'(offset));
   end

endmodule

// ==== verilog/mem_bank.sv ====
`timescale 1ns/1ns
/* row_bits + 5 must not exceed 16. Reads are registered while mem_en is high,
   and rows come up undefined */
module mem_bank import mem_bus_pkg::*; #(parameter int row_bits = 10)
(
   input  logic                   bus_clk,
   input  logic [15:0]            addr,
   input  logic                   mem_en,
   input  logic                   mem_wr,
   input  logic [line_bits-1:0]   wr_line,
   input  logic [line_bits/8-1:0] byte_en,
   output logic [line_bits-1:0]   rd_half
);

   mem_row_u            rows [2**row_bits];
   mem_row_u            rd_row;
   logic [row_bits-1:0] row_idx;
   logic                half_sel;

   assign row_idx  = addr[row_bits+4:5];
   assign half_sel = addr[4];

   always_ff @(posedge bus_clk)
   begin
      if (mem_en && mem_wr)
      begin
         // Byte view, offset into the selected half
         for (int b = 0; b < line_bits/8; b++)
         begin
            if (byte_en[b])
               rows[row_idx].bytes[{half_sel, 4'(b)}] <= wr_line[8*b +: 8];
         end
      end
      else if (mem_en)
         rd_row <= rows[row_idx];
   end

   // Half view
   assign rd_half = rd_row.half[half_sel];

endmodule

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/1ns
/* One bank of 2**row_bits rows of 32 bytes. At most two requests are held, one
   in the write latch and one in the memory stage */
module mem_subsystem import mem_bus_pkg::*;
#(
   parameter int mem_lat  = 3,
   parameter int row_bits = 10
)
(
   input  logic     bus_clk,
   input  logic     arst_n,
   input  bus_req_t bus_in,
   output bus_rsp_t bus_out,
   output logic     ack,
   output logic     br,
   input  logic     bg
);

   logic                   wr_full;
   logic                   stage_read_ready;
   logic                   load_wr;
   logic                   beat_en;
   logic [beat_bits-1:0]   beat_idx;
   logic                   resp_drive;
   logic                   resp_done;
   mem_entry_t             stage;
   logic                   stage_valid;
   logic                   timer_run;
   logic                   mem_en;
   logic                   mem_wr;
   logic                   mem_done;
   logic                   rd_load;
   logic [line_bits-1:0]   wr_line;
   logic [line_bits-1:0]   shifted_line;
   logic [line_bits/8-1:0] byte_en;
   logic [line_bits-1:0]   rd_half;

   // Timer sees an empty cycle when a read return ends
   assign timer_run = stage_valid & ~resp_done;
   assign rd_load   = mem_done & ~stage.rw;

   ////////////////////////////////////////////////////////////
   // Control

   bus_ctrl u_bus_ctrl
   (
      .bus_clk          (bus_clk),
      .arst_n           (arst_n),
      .bus_in           (bus_in),
      .bg               (bg),
      .wr_full          (wr_full),
      .stage_read_ready (stage_read_ready),
      .ack              (ack),
      .br               (br),
      .load_wr          (load_wr),
      .beat_en          (beat_en),
      .beat_idx         (beat_idx),
      .resp_drive       (resp_drive),
      .resp_done        (resp_done)
   );

   req_latches u_req_latches
   (
      .bus_clk          (bus_clk),
      .arst_n           (arst_n),
      .bus_in           (bus_in),
      .load_wr          (load_wr),
      .line_in          (wr_line),
      .mem_done         (mem_done),
      .resp_done        (resp_done),
      .wr_full          (wr_full),
      .stage            (stage),
      .stage_valid      (stage_valid),
      .stage_read_ready (stage_read_ready)
   );

   mem_timer #(.mem_lat(mem_lat)) u_mem_timer
   (
      .bus_clk     (bus_clk),
      .arst_n      (arst_n),
      .stage_valid (timer_run),
      .stage_rw    (stage.rw),
      .mem_en      (mem_en),
      .mem_wr      (mem_wr),
      .mem_done    (mem_done)
   );

   ////////////////////////////////////////////////////////////
   // Datapath

   line_buffer u_line_buffer
   (
      .bus_clk    (bus_clk),
      .arst_n     (arst_n),
      .bus_in     (bus_in),
      .beat_en    (beat_en),
      .beat_idx   (beat_idx),
      .rd_load    (rd_load),
      .rd_half    (rd_half),
      .resp_drive (resp_drive),
      .line_out   (wr_line),
      .bus_out    (bus_out),
      .dest       (stage.src)
   );

   byte_shifter u_byte_shifter
   (
      .line_in  (stage.line),
      .offset   (stage.addr[3:0]),
      .line_out (shifted_line),
      .byte_en  (byte_en)
   );

   mem_bank #(.row_bits(row_bits)) u_mem_bank
   (
      .bus_clk (bus_clk),
      .addr    (stage.addr),
      .mem_en  (mem_en),
      .mem_wr  (mem_wr),
      .wr_line (shifted_line),
      .byte_en (byte_en),
      .rd_half (rd_half)
   );

endmodule

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
/* Inputs change on the falling clock edge and bg comes from a grant model.
   Reads only cover lines that were written before */
module tb_mem_subsystem import mem_bus_pkg::*;
();

   localparam int period     = 8;
   localparam int n_requests = 17;

   logic     bus_clk = 1'b0;
   logic     arst_n;
   bus_req_t bus_in;
   bus_rsp_t bus_out;
   logic     ack;
   logic     br;
   logic     bg = 1'b0;

   // Reference memory with one byte per address
   logic [7:0]  ref_mem [0:65535];
   logic [15:0] lfsr = 16'd21;
   logic        read_acked = 1'b0;
   logic        write_data = 1'b0;
   int          grant_delay;
   int          checks = 0;
   int          errors = 0;
   int          beats_taken = 0;
   int          acks_seen = 0;

   mem_subsystem #(.mem_lat(3), .row_bits(10)) dut
   (
      .bus_clk (bus_clk),
      .arst_n  (arst_n),
      .bus_in  (bus_in),
      .bus_out (bus_out),
      .ack     (ack),
      .br      (br),
      .bg      (bg)
   );

   always #(period/2) bus_clk = ~bus_clk;

   ////////////////////////////////////////////////////////////
   // Helpers

   // Galois LFSR stepped once per bit taken
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 16'hB400;
      return out;
   endfunction

   function automatic void check_value(input logic [31:0] got, input logic [31:0] exp,
                                       input string what);
      checks++;
      assert (got == exp)
      else
      begin
         errors++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endfunction

   function automatic logic [3:0][31:0] pattern_line(input logic [31:0] seed);
      logic [3:0][31:0] line;
      for (int i = 0; i < beats; i++)
         line[i] = seed + 32'(i) * 32'h0404_0404 + 32'h0302_0100;
      return line;
   endfunction

   // Line shifted up by the byte offset while bytes below it stay untouched
   function automatic void ref_write(input logic [15:0] addr, input logic [127:0] line);
      int off;
      off = int'(addr[3:0]);
      for (int j = off; j < 16; j++)
         ref_mem[{addr[15:4], 4'(j)}] = line[8*(j-off) +: 8];
   endfunction

   function automatic logic [31:0] ref_word(input logic [15:0] addr, input int i);
      logic [31:0] w;
      for (int k = 0; k < 4; k++)
         w[8*k +: 8] = ref_mem[{addr[15:4], 4'(4*i + k)}];
      return w;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus master tasks

   task automatic bus_write(input logic [15:0] addr, input logic [2:0] src,
                            input logic [3:0][31:0] words);
      int taken;
      ref_write(addr, words);
      @(negedge bus_clk);
      bus_in.valid = 1'b1;
      bus_in.rw    = 1'b1;
      bus_in.addr  = addr;
      bus_in.src   = src;
      bus_in.data  = 32'h0;
      @(negedge bus_clk);
      while (!ack)
         @(negedge bus_clk);
      taken        = beats_taken;
      bus_in.valid = 1'b0;
      for (int i = 0; i < beats; i++)
      begin
         @(negedge bus_clk);
         bus_in.valid = 1'b1;
         bus_in.data  = words[i];
         write_data   = 1'b1;
      end
      @(negedge bus_clk);
      bus_in     = '0;
      write_data = 1'b0;
      check_value(32'(beats_taken - taken), 32'(beats), "write beats taken");
   endtask

   task automatic bus_read(input logic [15:0] addr, input logic [2:0] src);
      logic [3:0][31:0] expected;
      for (int i = 0; i < beats; i++)
         expected[i] = ref_word(addr, i);
      @(negedge bus_clk);
      bus_in.valid = 1'b1;
      bus_in.rw    = 1'b0;
      bus_in.addr  = addr;
      bus_in.src   = src;
      bus_in.data  = 32'h0;
      @(negedge bus_clk);
      while (!ack)
         @(negedge bus_clk);
      bus_in     = '0;
      read_acked = 1'b1;
      while (!bus_out.drive)
         @(negedge bus_clk);
      for (int i = 0; i < beats; i++)
      begin
         if (i > 0)
         begin
            @(negedge bus_clk);
            check_value(32'(bus_out.drive), 32'h1, "drive");
         end
         check_value(32'(bus_out.dest), 32'(src), "dest");
         check_value(bus_out.data, expected[i], "read beat");
      end
      @(negedge bus_clk);
      check_value(32'(bus_out.drive), 32'h0, "drive after beat 3");
      read_acked = 1'b0;
   endtask

   task automatic check_reset();
      arst_n = 1'b0;
      repeat (16)
      begin
         @(negedge bus_clk);
         if (!arst_n && $time >= 8 * period)
            arst_n = 1'b1;
         check_value(32'({ack, br, bus_out.drive, dut.mem_en, dut.mem_wr}), 32'h0,
                     "ack, br, drive, mem_en, mem_wr");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests

   task automatic aligned_write_read();
      bus_write(16'h0040, 3'b001, pattern_line(32'h1000_0000));
      bus_read(16'h0040, 3'b010);
   endtask

   task automatic offset_write_read();
      bus_write(16'h0080, 3'b010, pattern_line(32'h2000_0000));
      bus_write(16'h0085, 3'b100, pattern_line(32'h2A00_0000));
      bus_read(16'h0080, 3'b001);
   endtask

   // Bit 4 picks the half of one row
   task automatic half_select();
      bus_write(16'h0100, 3'b100, pattern_line(32'h3000_0000));
      bus_write(16'h0110, 3'b100, pattern_line(32'h3B00_0000));
      bus_read(16'h0100, 3'b001);
      bus_read(16'h0110, 3'b010);
   endtask

   task automatic back_pressure();
      bus_write(16'h00C0, 3'b010, pattern_line(32'h4000_0000));
      bus_write(16'h00C3, 3'b010, pattern_line(32'h4C00_0000));
      bus_write(16'h00CA, 3'b001, pattern_line(32'h4E00_0000));
      bus_read(16'h00C0, 3'b100);
   endtask

   // A write comes in while the read waits in the memory stage
   task automatic delayed_grant();
      bus_write(16'h0200, 3'b100, pattern_line(32'h6000_0000));
      fork
         bus_read(16'h0200, 3'b001);
         begin
            wait (read_acked);
            bus_write(16'h0220, 3'b010, pattern_line(32'h7000_0000));
         end
      join
      bus_read(16'h0220, 3'b010);
   endtask

   ////////////////////////////////////////////////////////////
   // Grant model and bus monitor

   always
   begin
      @(negedge bus_clk);
      if (br && !bg)
      begin
         grant_delay = 1 + int'(lfsr_bit()) + int'(lfsr_bit());
         repeat (grant_delay - 1)
         begin
            @(negedge bus_clk);
            check_value(32'(br), 32'h1, "br before grant");
         end
         bg = 1'b1;
         @(negedge bus_clk);
         check_value(32'(br), 32'h0, "br after grant");
         check_value(32'(bus_out.drive), 32'h1, "drive after grant");
         bg = 1'b0;
      end
   end

   always @(posedge bus_clk)
   begin
      if (arst_n)
      begin
         if (dut.beat_en)
            beats_taken++;
         if (ack)
            acks_seen++;
         assert (!(bus_out.drive && write_data))
         else
         begin
            errors++;
            $display("Error at %0t ns: read beat driven during a write beat", $time);
         end
      end
   end

   // Watchdog
   initial
   begin
      #((n_requests * 200 + 8) * period);
      $display("Timeout: the tests did not finish in %0d cycles", n_requests * 200 + 8);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      bus_in = '0;
      arst_n = 1'b0;
      check_reset();
      aligned_write_read();
      offset_write_read();
      half_select();
      back_pressure();
      delayed_grant();
      repeat (4)
         @(negedge bus_clk);
      check_value(32'(acks_seen), 32'(n_requests), "acknowledged requests");
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
common/mem_bus_pkg.sv
bus_ctrl/bus_ctrl.sv
verilog/req_latches.sv
verilog/line_buffer.sv
verilog/mem_timer.sv
verilog/byte_shifter.sv
verilog/mem_bank.sv
verilog/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== Makefile ====
TOP = tb_mem_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module mem_subsystem -f verilog.f

clean:
	rm -rf obj_dir sim.log
